//--- common/mem_infra_pkg.sv
`default_nettype none

package mem_infra_pkg;

  // Configuration port geometry
  localparam int cfg_addr_w = 2;
  localparam int cfg_data_w = 8;

  // Signed phase offset in fine-shift taps, two's complement
  localparam int ps_off_w = 8;

  // Register map

  // Signed target offset, a write also starts a move
  localparam logic [cfg_addr_w-1:0] addr_ps_target = 2'd0;

  // Read-only status
  // bit 0 busy, bit 1 rstdiv0, rest zero
  localparam logic [cfg_addr_w-1:0] addr_status = 2'd1;

  // Read-only current signed offset
  localparam logic [cfg_addr_w-1:0] addr_ps_offset = 2'd2;

  // Lock-loss count, any write clears it
  localparam logic [cfg_addr_w-1:0] addr_lock_loss = 2'd3;

endpackage

`default_nettype wire

//--- src/reset_sync.sv
`timescale 1ns/1ps
`default_nettype none

module reset_sync #(
  // Cycles from release of the reset condition to rstdiv0 low
  parameter int rst_div_sync_num = 33
) (
  input  logic clk_bufg,
  input  logic rst_tmp,
  input  logic pll_lock,
  input  logic iodelay_ctrl_rdy,
  output logic rstdiv0
);

  // Any of these holds the controller in reset
  logic rst_comb;

  // Release chain, all ones while in reset
  logic [rst_div_sync_num-1:0] rstdiv0_sync_r;

  // System reset, clock manager not locked, or IDELAY not calibrated
  assign rst_comb = rst_tmp | ~pll_lock | ~iodelay_ctrl_rdy;

  // Assert at once, even with no clock running
  // Deassert only after a run of stable clocks has passed
  always_ff @(posedge clk_bufg or posedge rst_comb) begin
    if (rst_comb) begin
      rstdiv0_sync_r <= '1;
    end else begin
      // Zero enters at bit 0 and walks up to the top
      rstdiv0_sync_r <= rstdiv0_sync_r << 1;
    end
  end

  // Top bit clears on the last edge of the chain
  assign rstdiv0 = rstdiv0_sync_r[rst_div_sync_num-1];

endmodule

`default_nettype wire

//--- src/lock_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module lock_monitor import mem_infra_pkg::*; (
  input  logic                  clk_bufg,
  input  logic                  rst_tmp,
  input  logic                  pll_lock,
  input  logic                  lock_clr,
  output logic [cfg_data_w-1:0] lock_loss_cnt
);

  // Previous lock level for edge detection
  logic lock_d;
  // High for one cycle when lock drops
  logic lock_fall;

  // Locked last cycle, unlocked now
  assign lock_fall = lock_d & ~pll_lock;

  // Starts low so a clock manager still locking after reset is not counted
  always_ff @(posedge clk_bufg or posedge rst_tmp) begin
    if (rst_tmp) begin
      lock_d <= 1'b0;
    end else begin
      lock_d <= pll_lock;
    end
  end

  // Saturating count of lock drops
  always_ff @(posedge clk_bufg or posedge rst_tmp) begin
    if (rst_tmp) begin
      lock_loss_cnt <= '0;
    end else if (lock_clr) begin
      // Software clear wins over a drop in the same cycle
      lock_loss_cnt <= '0;
    end else if (lock_fall && (lock_loss_cnt != '1)) begin
      lock_loss_cnt <= lock_loss_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- phase_shift/ps_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ps_regs import mem_infra_pkg::*; (
  input  logic                       clk_bufg,
  input  logic                       rst_tmp,
  // Configuration port
  input  logic                       cfg_wr,
  input  logic [cfg_addr_w-1:0]      cfg_addr,
  input  logic [cfg_data_w-1:0]      cfg_wdata,
  output logic [cfg_data_w-1:0]      cfg_rdata,
  // To the phase controller and lock monitor
  output logic signed [ps_off_w-1:0] ps_target,
  output logic                       ps_go,
  output logic                       lock_clr,
  // Read-back sources
  input  logic                       ps_busy,
  input  logic signed [ps_off_w-1:0] ps_offset,
  input  logic                       rstdiv0,
  input  logic [cfg_data_w-1:0]      lock_loss_cnt
);

  // Write decode
  logic wr_target;
  logic wr_lock_clr;

  // Status word, busy in bit 0 and reset in bit 1
  logic [cfg_data_w-1:0] status_word;

  assign wr_target   = cfg_wr && (cfg_addr == addr_ps_target);
  assign wr_lock_clr = cfg_wr && (cfg_addr == addr_lock_loss);

  assign status_word = {{(cfg_data_w-2){1'b0}}, rstdiv0, ps_busy};

  // Target register
  // Kept across internal resets so software can read back what it asked for
  always_ff @(posedge clk_bufg or posedge rst_tmp) begin
    if (rst_tmp) begin
      ps_target <= '0;
    end else if (wr_target) begin
      // Raw data word taken as two's complement taps
      ps_target <= signed'(cfg_wdata);
    end
  end

  // Go and clear pulses
  // Both land on the cycle after the write, together with the new target
  always_ff @(posedge clk_bufg or posedge rst_tmp) begin
    if (rst_tmp) begin
      ps_go    <= 1'b0;
      lock_clr <= 1'b0;
    end else begin
      ps_go    <= wr_target;
      lock_clr <= wr_lock_clr;
    end
  end

  // Read-back mux, purely combinational on the address
  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      addr_ps_target: begin
        cfg_rdata = ps_target;
      end
      addr_status: begin
        cfg_rdata = status_word;
      end
      addr_ps_offset: begin
        cfg_rdata = ps_offset;
      end
      addr_lock_loss: begin
        cfg_rdata = lock_loss_cnt;
      end
      default: begin
        cfg_rdata = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- phase_shift/ps_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ps_ctrl import mem_infra_pkg::*; (
  input  logic                       clk_bufg,
  input  logic                       rstdiv0,
  // From the register block
  input  logic signed [ps_off_w-1:0] ps_target,
  input  logic                       ps_go,
  // Clock manager fine phase shift
  input  logic                       psdone,
  output logic                       psen,
  output logic                       psincdec,
  // Status back to the register block
  output logic                       ps_busy,
  output logic signed [ps_off_w-1:0] ps_offset
);

  // FSM encoding
  localparam logic [1:0] st_idle      = 2'd0;
  localparam logic [1:0] st_wait_done = 2'd1;
  localparam logic [1:0] st_gap       = 2'd2;

  // One fine-shift tap
  localparam logic signed [ps_off_w-1:0] one_tap = 1;

  logic [1:0]                 state;
  logic                       at_target;
  logic                       step_up;
  logic signed [ps_off_w-1:0] offset_next;

  // Signed compare of where we are against where software wants to be
  assign at_target = (ps_target == ps_offset);
  assign step_up   = (ps_target > ps_offset);

  // Offset once the step in flight completes
  assign offset_next = psincdec ? (ps_offset + one_tap) : (ps_offset - one_tap);

  // Offset follows the clock manager phase, which also resets with lock
  always_ff @(posedge clk_bufg or posedge rstdiv0) begin
    if (rstdiv0) begin
      state     <= st_idle;
      psen      <= 1'b0;
      psincdec  <= 1'b0;
      ps_busy   <= 1'b0;
      ps_offset <= '0;
    end else begin
      // psen is a single-cycle strobe
      psen <= 1'b0;
      case (state)
        st_idle: begin
          // A move only starts on a write to the target
          if (ps_go && !at_target) begin
            psen     <= 1'b1;
            psincdec <= step_up;
            ps_busy  <= 1'b1;
            state    <= st_wait_done;
          end
        end
        st_wait_done: begin
          // Direction stays on the pins until the clock manager answers
          if (psdone) begin
            ps_offset <= offset_next;
            psincdec  <= 1'b0;
            // Busy drops with the step that lands on the target
            ps_busy   <= (offset_next != ps_target);
            state     <= st_gap;
          end
        end
        st_gap: begin
          // One idle cycle between steps
          // target may have moved, so compare again
          if (!at_target) begin
            psen     <= 1'b1;
            psincdec <= step_up;
            ps_busy  <= 1'b1;
            state    <= st_wait_done;
          end else begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/mem_infra_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_infra_top import mem_infra_pkg::*; #(
  // Depth of the reset release chain in clk_bufg cycles
  parameter int rst_div_sync_num = 33
) (
  input  logic                  clk_bufg,
  input  logic                  rst_tmp,
  input  logic                  pll_lock,
  input  logic                  iodelay_ctrl_rdy,
  input  logic                  psdone,
  input  logic                  cfg_wr,
  input  logic [cfg_addr_w-1:0] cfg_addr,
  input  logic [cfg_data_w-1:0] cfg_wdata,
  output logic [cfg_data_w-1:0] cfg_rdata,
  output logic                  psen,
  output logic                  psincdec,
  output logic                  rstdiv0
);

  // Register block to phase controller
  logic signed [ps_off_w-1:0] ps_target;
  logic                       ps_go;
  logic                       ps_busy;
  logic signed [ps_off_w-1:0] ps_offset;

  // Register block to lock monitor
  logic                  lock_clr;
  logic [cfg_data_w-1:0] lock_loss_cnt;

  // Internal reset release after lock and IDELAY ready
  reset_sync #(
    .rst_div_sync_num (rst_div_sync_num)
  ) u_reset_sync (
    .clk_bufg         (clk_bufg),
    .rst_tmp          (rst_tmp),
    .pll_lock         (pll_lock),
    .iodelay_ctrl_rdy (iodelay_ctrl_rdy),
    .rstdiv0          (rstdiv0)
  );

  // Counts lock drops, runs on system reset only
  lock_monitor u_lock_monitor (
    .clk_bufg      (clk_bufg),
    .rst_tmp       (rst_tmp),
    .pll_lock      (pll_lock),
    .lock_clr      (lock_clr),
    .lock_loss_cnt (lock_loss_cnt)
  );

  // Software-visible registers
  ps_regs u_ps_regs (
    .clk_bufg      (clk_bufg),
    .rst_tmp       (rst_tmp),
    .cfg_wr        (cfg_wr),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .cfg_rdata     (cfg_rdata),
    .ps_target     (ps_target),
    .ps_go         (ps_go),
    .lock_clr      (lock_clr),
    .ps_busy       (ps_busy),
    .ps_offset     (ps_offset),
    .rstdiv0       (rstdiv0),
    .lock_loss_cnt (lock_loss_cnt)
  );

  // Fine phase stepping, held in reset with the rest of the controller
  ps_ctrl u_ps_ctrl (
    .clk_bufg  (clk_bufg),
    .rstdiv0   (rstdiv0),
    .ps_target (ps_target),
    .ps_go     (ps_go),
    .psdone    (psdone),
    .psen      (psen),
    .psincdec  (psincdec),
    .ps_busy   (ps_busy),
    .ps_offset (ps_offset)
  );

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  // Full clock period in ns
  parameter real period_ns = 4.0
) (
  output logic clk_bufg
);

  // Starts low, first rising edge half a period in
  initial begin
    clk_bufg = 1'b0;
  end

  always #(period_ns / 2.0) clk_bufg = ~clk_bufg;

endmodule

`default_nettype wire

//--- dv/mmcm_model.sv
`timescale 1ns/1ps
`default_nettype none

module mmcm_model #(
  // Cycles from a psen pulse to its psdone
  parameter int ps_delay = 12
) (
  input  logic clk_bufg,
  input  logic rst_tmp,
  input  logic lock_req,
  input  logic psen,
  output logic pll_lock,
  output logic psdone
);

  // One bit per cycle of phase-shift latency
  logic [ps_delay-1:0] done_pipe;

  // Lock follows the testbench control directly
  assign pll_lock = lock_req;

  // A step in flight is lost when lock drops
  always_ff @(posedge clk_bufg or posedge rst_tmp) begin
    if (rst_tmp) begin
      done_pipe <= '0;
    end else if (!lock_req) begin
      done_pipe <= '0;
    end else begin
      done_pipe <= {done_pipe[ps_delay-2:0], psen};
    end
  end

  // One-cycle answer, ps_delay cycles after the request
  assign psdone = done_pipe[ps_delay-1];

endmodule

`default_nettype wire

//--- dv/mem_infra_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mem_infra_asserts (
  input logic clk_bufg,
  input logic rstdiv0,
  input logic psen,
  input logic psdone
);

  // High from a psen pulse until its psdone
  logic done_pending;

  always_ff @(posedge clk_bufg or posedge rstdiv0) begin
    if (rstdiv0) begin
      done_pending <= 1'b0;
    end else if (psen) begin
      done_pending <= 1'b1;
    end else if (psdone) begin
      done_pending <= 1'b0;
    end
  end

  // Strobe lasts one cycle only
  psen_single: assert property (@(posedge clk_bufg) disable iff (rstdiv0) psen |=> !psen)
    else $error("psen high for two cycles in a row");

  // No new step before the clock manager answers
  psen_waits: assert property (@(posedge clk_bufg) disable iff (rstdiv0) done_pending |-> !psen)
    else $error("psen issued while a step was still waiting for psdone");

  // Quiet while the controller is held in reset
  psen_in_reset: assert property (@(posedge clk_bufg) rstdiv0 |-> !psen)
    else $error("psen high while rstdiv0 is asserted");

endmodule

bind ps_ctrl mem_infra_asserts u_mem_infra_asserts (
  .clk_bufg (clk_bufg),
  .rstdiv0  (rstdiv0),
  .psen     (psen),
  .psdone   (psdone)
);

`default_nettype wire

//--- dv/mem_infra_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_infra_tb import mem_infra_pkg::*; ();

  // Longest test is the retarget with at most 16 steps of 14 cycles
  // All tests together take about 30 steps plus resets and idle waits
  // Whole run stays far below this
  localparam int max_cycles = 5000;

  logic                  clk_bufg;
  logic                  rst_tmp;
  logic                  lock_req;
  logic                  pll_lock;
  logic                  iodelay_ctrl_rdy;
  logic                  psdone;
  logic                  cfg_wr;
  logic [cfg_addr_w-1:0] cfg_addr;
  logic [cfg_data_w-1:0] cfg_wdata;
  logic [cfg_data_w-1:0] cfg_rdata;
  logic                  psen;
  logic                  psincdec;
  logic                  rstdiv0;

  int cycle_cnt = 0;
  int err_count = 0;
  int check_count = 0;
  int test_count = 0;
  int test_err_start = 0;
  // Running psen pulse counts by direction
  int up_pulses = 0;
  int dn_pulses = 0;
  int seed = 32'h157e_179c;

  tb_clk_gen #(.period_ns(4.0)) u_clk_gen (.clk_bufg(clk_bufg));

  mmcm_model #(.ps_delay(12)) u_mmcm (
    .clk_bufg (clk_bufg),
    .rst_tmp  (rst_tmp),
    .lock_req (lock_req),
    .psen     (psen),
    .pll_lock (pll_lock),
    .psdone   (psdone)
  );

  mem_infra_top #(.rst_div_sync_num(8)) DUT (
    .clk_bufg         (clk_bufg),
    .rst_tmp          (rst_tmp),
    .pll_lock         (pll_lock),
    .iodelay_ctrl_rdy (iodelay_ctrl_rdy),
    .psdone           (psdone),
    .cfg_wr           (cfg_wr),
    .cfg_addr         (cfg_addr),
    .cfg_wdata        (cfg_wdata),
    .cfg_rdata        (cfg_rdata),
    .psen             (psen),
    .psincdec         (psincdec),
    .rstdiv0          (rstdiv0)
  );

  // Strobes are registered so the value before the edge is stable
  always @(posedge clk_bufg) begin
    if (psen) begin
      if (psincdec) begin
        up_pulses = up_pulses + 1;
      end else begin
        dn_pulses = dn_pulses + 1;
      end
    end
  end

  // Run limit
  always @(posedge clk_bufg) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("Timeout after %0d cycles, a wait on the DUT never ended", cycle_cnt);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic check(input string test_name, input int expected, input int actual);
    check_count = check_count + 1;
    if (expected != actual) begin
      $display("Fail %s: expected %0d actual %0d", test_name, expected, actual);
      err_count = err_count + 1;
    end
  endtask

  task automatic begin_test();
    test_count = test_count + 1;
    test_err_start = err_count;
  endtask

  task automatic end_test(input string test_name);
    if (err_count == test_err_start) begin
      $display("%s: ok", test_name);
    end else begin
      $display("%s: %0d errors", test_name, err_count - test_err_start);
    end
  endtask

  task automatic write_reg(input logic [cfg_addr_w-1:0] addr, input logic [cfg_data_w-1:0] data);
    @(negedge clk_bufg);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk_bufg);
    cfg_wr    = 1'b0;
  endtask

  // Read data is combinational so it settles just after the address
  task automatic read_reg(input logic [cfg_addr_w-1:0] addr, output logic [cfg_data_w-1:0] data);
    @(negedge clk_bufg);
    cfg_addr = addr;
    #1;
    data = cfg_rdata;
  endtask

  // Count cycles until rstdiv0 falls with a cap of 40
  task automatic wait_release(output int n);
    n = 0;
    do begin
      @(negedge clk_bufg);
      n = n + 1;
    end while (rstdiv0 && (n < 40));
  endtask

  // Poll the busy bit until the move ends
  task automatic wait_idle();
    logic [cfg_data_w-1:0] status;
    do begin
      read_reg(addr_status, status);
    end while (status[0]);
  endtask

  task automatic test_reset_release();
    logic [cfg_data_w-1:0] status;
    int n;
    begin_test();
    read_reg(addr_status, status);
    check("reset_release", 2, int'(status));
    @(negedge clk_bufg);
    rst_tmp = 1'b0;
    wait_release(n);
    // Release alignment allows one extra edge
    check("reset_release", (n == 9) ? 9 : 8, n);
    read_reg(addr_status, status);
    check("reset_release", 0, int'(status[1]));
    check("reset_release", 0, int'(status));
    end_test("reset_release");
  endtask

  task automatic test_increment();
    logic [cfg_data_w-1:0] rdata;
    int up0;
    int dn0;
    begin_test();
    up0 = up_pulses;
    dn0 = dn_pulses;
    write_reg(addr_ps_target, 8'h05);
    wait_idle();
    check("increment", 5, up_pulses - up0);
    check("increment", 0, dn_pulses - dn0);
    read_reg(addr_ps_offset, rdata);
    check("increment", 5, int'(rdata));
    read_reg(addr_status, rdata);
    check("increment", 0, int'(rdata[0]));
    end_test("increment");
  endtask

  task automatic test_decrement_noop();
    logic [cfg_data_w-1:0] rdata;
    int up0;
    int dn0;
    begin_test();
    up0 = up_pulses;
    dn0 = dn_pulses;
    // From +5 down to -3
    write_reg(addr_ps_target, 8'hfd);
    wait_idle();
    check("decrement_noop", 8, dn_pulses - dn0);
    check("decrement_noop", 0, up_pulses - up0);
    read_reg(addr_ps_offset, rdata);
    check("decrement_noop", 8'hfd, int'(rdata));
    // Same target again must not move
    up0 = up_pulses;
    dn0 = dn_pulses;
    write_reg(addr_ps_target, 8'hfd);
    repeat (20) @(negedge clk_bufg);
    check("decrement_noop", 0, (up_pulses - up0) + (dn_pulses - dn0));
    read_reg(addr_status, rdata);
    check("decrement_noop", 0, int'(rdata[0]));
    end_test("decrement_noop");
  endtask

  task automatic test_lock_loss();
    logic [cfg_data_w-1:0] rdata;
    int n;
    begin_test();
    @(negedge clk_bufg);
    lock_req = 1'b0;
    @(negedge clk_bufg);
    check("lock_loss", 1, int'(rstdiv0));
    repeat (2) @(negedge clk_bufg);
    lock_req = 1'b1;
    wait_release(n);
    check("lock_loss", (n == 9) ? 9 : 8, n);
    read_reg(addr_lock_loss, rdata);
    check("lock_loss", 1, int'(rdata));
    // Phase restarts at zero with the clock manager
    read_reg(addr_ps_offset, rdata);
    check("lock_loss", 0, int'(rdata));
    write_reg(addr_lock_loss, 8'h5a);
    read_reg(addr_lock_loss, rdata);
    check("lock_loss", 0, int'(rdata));
    end_test("lock_loss");
  endtask

  task automatic test_idelay_not_ready();
    int held;
    int n;
    begin_test();
    held = 0;
    @(negedge clk_bufg);
    iodelay_ctrl_rdy = 1'b0;
    repeat (30) begin
      @(negedge clk_bufg);
      if (rstdiv0) begin
        held = held + 1;
      end
    end
    check("idelay_not_ready", 30, held);
    iodelay_ctrl_rdy = 1'b1;
    wait_release(n);
    check("idelay_not_ready", (n == 9) ? 9 : 8, n);
    end_test("idelay_not_ready");
  endtask

  task automatic test_retarget_busy();
    logic [cfg_data_w-1:0] rdata;
    int r;
    int pick;
    int v;
    int neg_v;
    int mag;
    int k;
    int up0;
    int dn0;
    int exp_up;
    int exp_dn;
    begin_test();
    r = $random(seed);
    pick = $unsigned(r) % 17;
    v = pick - 8;
    neg_v = -v;
    mag = (v < 0) ? -v : v;
    // Retarget after about half of the first move
    k = (mag + 1) / 2;
    up0 = up_pulses;
    dn0 = dn_pulses;
    write_reg(addr_ps_target, v[7:0]);
    while (((up_pulses - up0) + (dn_pulses - dn0)) < k) begin
      @(negedge clk_bufg);
    end
    write_reg(addr_ps_target, neg_v[7:0]);
    wait_idle();
    // k steps out toward v then k plus mag steps back to -v
    if (v > 0) begin
      exp_up = k;
      exp_dn = k + mag;
    end else begin
      exp_up = k + mag;
      exp_dn = k;
    end
    check("retarget_busy", exp_up, up_pulses - up0);
    check("retarget_busy", exp_dn, dn_pulses - dn0);
    read_reg(addr_ps_offset, rdata);
    check("retarget_busy", neg_v & 255, int'(rdata));
    read_reg(addr_ps_target, rdata);
    check("retarget_busy", neg_v & 255, int'(rdata));
    end_test("retarget_busy");
  endtask

  initial begin
    rst_tmp          = 1'b1;
    lock_req         = 1'b1;
    iodelay_ctrl_rdy = 1'b1;
    cfg_wr           = 1'b0;
    cfg_addr         = '0;
    cfg_wdata        = '0;
    // First test reads status and then drops the system reset 8 cycles in
    repeat (6) @(negedge clk_bufg);
    test_reset_release();
    test_increment();
    test_decrement_noop();
    test_lock_loss();
    test_idelay_not_ready();
    test_retarget_busy();
    $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mem_infra_top.f
common/mem_infra_pkg.sv
src/reset_sync.sv
src/lock_monitor.sv
phase_shift/ps_regs.sv
phase_shift/ps_ctrl.sv
src/mem_infra_top.sv
dv/tb_clk_gen.sv
dv/mmcm_model.sv
dv/mem_infra_asserts.sv
dv/mem_infra_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass is decided from the run log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module mem_infra_tb \
  -f mem_infra_top.f -o mem_infra_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/mem_infra_sim > sim.log 2>&1 || true
cat sim.log
grep -qF "*** TEST PASSED ***" sim.log && exit 0 || exit 1
